// File: list.f
design/fill_pkg.sv
design/link_pkg.sv
design/header_decode.sv
design/burst_fetch.sv
design/response_tx.sv
design/fill_sequencer.sv
design/fill_readout.sv
tb/fill_mem_model.sv
tb/fill_readout_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fill readout simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module fill_readout_tb -f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vfill_readout_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

// File: tb/fill_readout_tb.sv
// Fill readout testbench
module fill_readout_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned rng_seed     = 32'h8a4d40fa;
	localparam int          done_timeout = 2000;
	localparam int          word_w       = $bits(link_pkg::word_t);

	logic                  clk;
	logic                  arst_n;
	logic                  run_sm;
	link_pkg::word_t       csn;
	link_pkg::word_t       cc;
	logic                  fifo_empty;
	fill_pkg::header_t     fifo_header;
	logic                  ddr3_one_burst_rdy;
	fill_pkg::header_t     ddr3_one_burst_data;
	logic                  tx_tready;
	logic                  readout_pause;
	logic                  sm_running;
	logic                  sm_done;
	logic                  fifo_rd_en;
	fill_pkg::burst_addr_t ddr3_rd_burst_addr;
	logic                  ddr3_rd_one_burst;
	logic                  tx_tvalid;
	logic                  tx_tlast;
	link_pkg::word_t       tx_data;
	logic                  bp_on;

	// Seen on the DUT outputs
	link_pkg::word_t       got_words[$];
	logic                  got_lasts[$];
	fill_pkg::burst_addr_t got_addrs[$];
	int                    pop_count;
	int                    done_count;
	logic                  tvalid_prev;

	// Expected for the running test
	link_pkg::word_t       exp_words[$];
	fill_pkg::burst_addr_t exp_addrs[$];
	int                    exp_pops;

	fill_readout fill_readout_i (.*);

	fill_mem_model fill_mem_model_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Random link back-pressure while bp_on is set
	initial begin
		tx_tready     <= 1'b1;
		readout_pause <= 1'b0;
		forever begin
			@(posedge clk);
			if (bp_on) begin
				tx_tready     <= ($urandom % 4) != 0;
				readout_pause <= ($urandom % 8) == 0;
			end else begin
				tx_tready     <= 1'b1;
				readout_pause <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checking

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			abort_run();
		end
	endtask

	// Output monitor sampling between rising edges
	initial begin
		tvalid_prev = 1'b0;
		forever begin
			@(negedge clk);
			if (arst_n) begin
				if (tx_tvalid) begin
					got_words.push_back(tx_data);
					got_lasts.push_back(tx_tlast);
				end
				if (tx_tlast && !tx_tvalid) begin
					$display("tx_tlast was high without tx_tvalid");
					abort_run();
				end
				if (tx_tvalid && tvalid_prev) begin
					$display("tx_tvalid stayed high for more than one cycle");
					abort_run();
				end
				if (fifo_rd_en)
					pop_count++;
				if (ddr3_rd_one_burst)
					got_addrs.push_back(ddr3_rd_burst_addr);
				if (sm_done)
					done_count++;
				tvalid_prev = tx_tvalid;
			end
		end
	end

	task automatic compare_response(input string name);
		int i;
		check_value({"tx_data count in ", name}, got_words.size(), exp_words.size());
		for (i = 0; i < exp_words.size(); i++) begin
			check_value($sformatf("tx_data word %0d in %s", i, name), got_words[i], exp_words[i]);
			// Only the final word carries tlast
			check_value($sformatf("tx_tlast word %0d in %s", i, name), got_lasts[i],
				i == exp_words.size() - 1);
		end
		check_value({"fifo_rd_en pulses in ", name}, pop_count, exp_pops);
		check_value({"ddr3_rd_one_burst count in ", name}, got_addrs.size(), exp_addrs.size());
		for (i = 0; i < exp_addrs.size(); i++)
			check_value($sformatf("ddr3_rd_burst_addr %0d in %s", i, name), got_addrs[i],
				exp_addrs[i]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	// Random header with the address and count fields set
	function automatic fill_pkg::header_t make_header(input fill_pkg::burst_addr_t addr,
		input fill_pkg::burst_count_t count);
		fill_pkg::header_t h;
		h = {$urandom, $urandom, $urandom, $urandom};
		h[fill_pkg::addr_msb:fill_pkg::addr_lsb]   = addr;
		h[fill_pkg::count_msb:fill_pkg::count_lsb] = count;
		return h;
	endfunction

	// Four words per burst with the low word first
	task automatic expect_burst(input fill_pkg::header_t b);
		for (int i = 0; i < link_pkg::words_per_burst; i++)
			exp_words.push_back(b[i*word_w +: word_w]);
	endtask

	task automatic begin_test(output link_pkg::word_t csn_v, output link_pkg::word_t cc_v);
		@(posedge clk);
		got_words.delete();
		got_lasts.delete();
		got_addrs.delete();
		exp_words.delete();
		exp_addrs.delete();
		pop_count  = 0;
		done_count = 0;
		exp_pops   = 0;
		fill_mem_model_i.clear_memory();
		csn_v = $urandom;
		cc_v  = $urandom;
		csn <= csn_v;
		cc  <= cc_v;
	endtask

	// Run one command up to sm_done, then release run_sm
	task automatic run_command(input string name);
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		@(posedge clk);
		run_sm <= 1'b1;
		while (!seen) begin
			@(negedge clk);
			if (sm_done) begin
				seen = 1'b1;
				// Sequencer is still busy in the cycle of sm_done
				check_value({"sm_running at sm_done in ", name}, sm_running, 1'b1);
			end else if (cycles >= done_timeout) begin
				$display("timeout: %s got no sm_done within %0d cycles", name, done_timeout);
				abort_run();
			end
			cycles++;
		end
		@(posedge clk);
		run_sm <= 1'b0;
		repeat (3) @(negedge clk);
		check_value({"sm_running after ", name}, sm_running, 1'b0);
		check_value({"sm_done pulses in ", name}, done_count, 1);
	endtask

	// Good header followed by count-1 data bursts
	task automatic run_matching_fill(input string name, input fill_pkg::burst_addr_t addr,
		input fill_pkg::burst_count_t count);
		link_pkg::word_t   csn_v;
		link_pkg::word_t   cc_v;
		fill_pkg::header_t h;
		begin_test(csn_v, cc_v);
		h = make_header(addr, count);
		fill_mem_model_i.push_header(h);
		fill_mem_model_i.set_burst(addr, h);
		exp_words.push_back(csn_v);
		exp_words.push_back(cc_v);
		expect_burst(h);
		exp_addrs.push_back(addr);
		for (int k = 1; k < count; k++) begin
			expect_burst(fill_mem_model_i.burst_pattern(addr + fill_pkg::burst_addr_t'(k)));
			exp_addrs.push_back(addr + fill_pkg::burst_addr_t'(k));
		end
		exp_pops = 1;
		run_command(name);
		compare_response(name);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_empty_fifo();
		link_pkg::word_t csn_v;
		link_pkg::word_t cc_v;
		begin_test(csn_v, cc_v);
		exp_words.push_back(csn_v);
		exp_words.push_back(~cc_v);
		run_command("empty fifo");
		compare_response("empty fifo");
	endtask

	task automatic test_single_burst();
		run_matching_fill("single burst", 23'h01_2345, 21'd1);
	endtask

	task automatic test_multi_burst();
		run_matching_fill("three bursts", 23'h40_0100, 21'd3);
	endtask

	// Memory copy differs from the FIFO header in one bit
	task automatic test_header_mismatch();
		link_pkg::word_t   csn_v;
		link_pkg::word_t   cc_v;
		fill_pkg::header_t h;
		begin_test(csn_v, cc_v);
		h = make_header(23'h15_0a0c, 21'd2);
		fill_mem_model_i.push_header(h);
		fill_mem_model_i.set_burst(23'h15_0a0c, h ^ (fill_pkg::header_t'(1) << 100));
		exp_words.push_back(csn_v);
		exp_words.push_back(~cc_v);
		exp_addrs.push_back(23'h15_0a0c);
		exp_pops = 1;
		run_command("header mismatch");
		compare_response("header mismatch");
	endtask

	task automatic test_back_pressure();
		@(negedge clk);
		bp_on = 1'b1;
		run_matching_fill("back-pressure", 23'h2a_aaa0, 21'd2);
		@(negedge clk);
		bp_on = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(rng_seed));
		bp_on = 1'b0;
		arst_n <= 1'b0;
		run_sm <= 1'b0;
		csn    <= '0;
		cc     <= '0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		// Quiet outputs out of reset
		check_value("sm_running", sm_running, 1'b0);
		check_value("sm_done", sm_done, 1'b0);
		check_value("tx_tvalid", tx_tvalid, 1'b0);
		check_value("tx_tlast", tx_tlast, 1'b0);
		check_value("fifo_rd_en", fifo_rd_en, 1'b0);
		check_value("ddr3_rd_one_burst", ddr3_rd_one_burst, 1'b0);
		test_empty_fifo();
		test_single_burst();
		test_multi_burst();
		test_header_mismatch();
		test_back_pressure();
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: tb/fill_mem_model.sv
// Header FIFO and burst memory model
module fill_mem_model (
	input  logic                  clk,
	input  logic                  fifo_rd_en,
	input  fill_pkg::burst_addr_t ddr3_rd_burst_addr,
	input  logic                  ddr3_rd_one_burst,
	output logic                  fifo_empty,
	output fill_pkg::header_t     fifo_header,
	output logic                  ddr3_one_burst_rdy,
	output fill_pkg::header_t     ddr3_one_burst_data
);
	timeunit 1ns;
	timeprecision 100ps;

	// Longest extra memory latency in cycles
	localparam int max_delay = 8;

	// FWFT header FIFO, head entry at index 0
	fill_pkg::header_t headers[$];
	// Bursts written by the testbench, others follow burst_pattern
	fill_pkg::header_t bursts[fill_pkg::burst_addr_t];

	logic                  empty_q = 1'b1;
	fill_pkg::header_t     head_q  = '0;
	logic                  rdy_q   = 1'b0;
	fill_pkg::header_t     data_q  = '0;
	logic                  busy    = 1'b0;
	fill_pkg::burst_addr_t req_addr;
	int                    wait_cnt;

	assign fifo_empty          = empty_q;
	assign fifo_header         = head_q;
	assign ddr3_one_burst_rdy  = rdy_q;
	assign ddr3_one_burst_data = data_q;

	//////////////////////////////////////////////////////////////////////
	// Memory contents

	// Every word carries the whole address, odd words inverted
	function automatic fill_pkg::header_t burst_pattern(input fill_pkg::burst_addr_t addr);
		fill_pkg::header_t b;
		for (int i = 0; i < 4; i++) begin
			b[i*32 +: 32] = {7'(i + 1), 2'b01, addr ^ {23{i[0]}}};
		end
		return b;
	endfunction

	task automatic push_header(input fill_pkg::header_t h);
		headers.push_back(h);
	endtask

	task automatic set_burst(input fill_pkg::burst_addr_t addr, input fill_pkg::header_t data);
		bursts[addr] = data;
	endtask

	task automatic clear_memory();
		headers.delete();
		bursts.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// FIFO side

	// Pop on the read strobe
	always @(posedge clk) begin
		if (fifo_rd_en && headers.size() > 0)
			void'(headers.pop_front());
	end

	// Outputs refresh between rising edges
	always @(negedge clk) begin
		empty_q <= (headers.size() == 0);
		head_q  <= (headers.size() > 0) ? headers[0] : '0;
	end

	//////////////////////////////////////////////////////////////////////
	// Memory side

	// Ready drops on the request, data and ready come back after a random wait
	always @(posedge clk) begin
		if (ddr3_rd_one_burst) begin
			rdy_q    <= 1'b0;
			req_addr = ddr3_rd_burst_addr;
			wait_cnt = $urandom % max_delay;
			busy     = 1'b1;
		end else if (busy) begin
			if (wait_cnt == 0) begin
				data_q <= bursts.exists(req_addr) ? bursts[req_addr] : burst_pattern(req_addr);
				rdy_q  <= 1'b1;
				busy   = 1'b0;
			end else begin
				wait_cnt = wait_cnt - 1;
			end
		end
	end

endmodule

// File: design/fill_readout.sv
// Fill readout top level
module fill_readout #(
	parameter int sync_stages = 2
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  run_sm,
	input  link_pkg::word_t       csn,
	input  link_pkg::word_t       cc,
	input  logic                  fifo_empty,
	input  fill_pkg::header_t     fifo_header,
	input  logic                  ddr3_one_burst_rdy,
	input  fill_pkg::header_t     ddr3_one_burst_data,
	input  logic                  tx_tready,
	input  logic                  readout_pause,
	output logic                  sm_running,
	output logic                  sm_done,
	output logic                  fifo_rd_en,
	output fill_pkg::burst_addr_t ddr3_rd_burst_addr,
	output logic                  ddr3_rd_one_burst,
	output logic                  tx_tvalid,
	output logic                  tx_tlast,
	output link_pkg::word_t       tx_data
);

	// Sequencer strobes and status
	logic                   hdr_take;
	logic                   hdr_match;
	logic                   fetch_start;
	logic                   fetch_req;
	logic                   advance;
	logic                   burst_ready;
	logic                   count_zero;
	logic                   send;
	logic                   sent;
	logic                   last;
	link_pkg::word_sel_t    word_sel;

	// Header fields and burst payload
	fill_pkg::burst_addr_t  start_addr;
	fill_pkg::burst_count_t start_count;
	fill_pkg::header_t      burst;

	//////////////////////////////////////////////////////////////////////
	// Control

	fill_sequencer fill_sequencer_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.run_sm      (run_sm),
		.fifo_empty  (fifo_empty),
		.hdr_match   (hdr_match),
		.burst_ready (burst_ready),
		.count_zero  (count_zero),
		.sent        (sent),
		.sm_running  (sm_running),
		.sm_done     (sm_done),
		.hdr_take    (hdr_take),
		.fetch_start (fetch_start),
		.fetch_req   (fetch_req),
		.advance     (advance),
		.send        (send),
		.word_sel    (word_sel),
		.last        (last)
	);

	//////////////////////////////////////////////////////////////////////
	// Decode, fetch and transmit

	header_decode header_decode_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.hdr_take    (hdr_take),
		.fifo_header (fifo_header),
		.burst_ready (burst_ready),
		.burst       (burst),
		.fifo_rd_en  (fifo_rd_en),
		.start_addr  (start_addr),
		.start_count (start_count),
		.hdr_match   (hdr_match)
	);

	burst_fetch #(
		.sync_stages (sync_stages)
	) burst_fetch_i (
		.clk                 (clk),
		.arst_n              (arst_n),
		.fetch_start         (fetch_start),
		.start_addr          (start_addr),
		.start_count         (start_count),
		.fetch_req           (fetch_req),
		.advance             (advance),
		.ddr3_one_burst_rdy  (ddr3_one_burst_rdy),
		.ddr3_one_burst_data (ddr3_one_burst_data),
		.ddr3_rd_burst_addr  (ddr3_rd_burst_addr),
		.ddr3_rd_one_burst   (ddr3_rd_one_burst),
		.burst_ready         (burst_ready),
		.burst               (burst),
		.count_zero          (count_zero)
	);

	response_tx #(
		.sync_stages (sync_stages)
	) response_tx_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.send          (send),
		.word_sel      (word_sel),
		.last          (last),
		.csn           (csn),
		.cc            (cc),
		.burst         (burst),
		.tx_tready     (tx_tready),
		.readout_pause (readout_pause),
		.tx_tvalid     (tx_tvalid),
		.tx_tlast      (tx_tlast),
		.tx_data       (tx_data),
		.sent          (sent)
	);

endmodule

// File: design/fill_sequencer.sv
// Read-fill command sequencer
module fill_sequencer (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                run_sm,
	input  logic                fifo_empty,
	input  logic                hdr_match,
	input  logic                burst_ready,
	input  logic                count_zero,
	input  logic                sent,
	output logic                sm_running,
	output logic                sm_done,
	output logic                hdr_take,
	output logic                fetch_start,
	output logic                fetch_req,
	output logic                advance,
	output logic                send,
	output link_pkg::word_sel_t word_sel,
	output logic                last
);

	typedef enum logic [3:0] {
		idle,
		check_fifo,
		error,
		take_header,
		fetch_header,
		wait_header,
		compare,
		echo_csn,
		echo_cc,
		send_burst,
		fetch_data,
		wait_data,
		done
	} state_t;

	state_t state;
	state_t state_next;
	state_t state_d;
	logic   entered;
	logic   error_flag;

	//////////////////////////////////////////////////////////////////////
	// Next state

	always_comb begin
		state_next = state;
		case (state)
			// Start straight away, run_sm gating is below
			idle:         state_next = check_fifo;
			check_fifo:   state_next = fifo_empty ? error : take_header;
			error:        state_next = echo_csn;
			take_header:  state_next = fetch_header;
			// Memory copy of the header sits at the start address
			fetch_header: state_next = wait_header;
			wait_header:  if (burst_ready) state_next = compare;
			// hdr_match is valid one cycle after burst_ready
			compare:      state_next = hdr_match ? echo_csn : error;
			echo_csn:     if (sent) state_next = echo_cc;
			echo_cc: begin
				// Good header goes on to resend the burst already held
				if (sent)
					state_next = error_flag ? done : send_burst;
			end
			send_burst: begin
				if (sent)
					state_next = count_zero ? done : fetch_data;
			end
			fetch_data:   state_next = wait_data;
			wait_data:    if (burst_ready) state_next = send_burst;
			done:         state_next = idle;
			default:      state_next = idle;
		endcase
	end

	// Dropping run_sm returns to idle from anywhere
	assign state_d = run_sm ? state_next : idle;

	//////////////////////////////////////////////////////////////////////
	// State and flags

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= idle;
			entered    <= 1'b0;
			error_flag <= 1'b0;
		end else begin
			state   <= state_d;
			// High in the first cycle of each state
			entered <= (state_d != state);
			// Error flag lives for one command
			if (state == idle)
				error_flag <= 1'b0;
			else if (state == error)
				error_flag <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs

	assign sm_running  = (state != idle);
	assign sm_done     = (state == done);
	assign hdr_take    = (state == take_header);
	assign fetch_start = (state == fetch_header);
	assign fetch_req   = (state == fetch_header) || (state == fetch_data);

	// Each send state is always entered from a different state
	assign send    = entered &&
		((state == echo_csn) || (state == echo_cc) || (state == send_burst));
	assign advance = entered && (state == send_burst);

	always_comb begin
		case (state)
			echo_csn: word_sel = link_pkg::sel_csn;
			echo_cc:  word_sel = error_flag ? link_pkg::sel_inv_cc : link_pkg::sel_cc;
			default:  word_sel = link_pkg::sel_burst;
		endcase
	end

	// count_zero settles long before the final burst word
	assign last = ((state == echo_cc) && error_flag) ||
		((state == send_burst) && count_zero);

endmodule

// File: design/response_tx.sv
// Response word transmitter
module response_tx #(
	parameter int sync_stages = 2
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                send,
	input  link_pkg::word_sel_t word_sel,
	input  logic                last,
	input  link_pkg::word_t     csn,
	input  link_pkg::word_t     cc,
	input  fill_pkg::header_t   burst,
	input  logic                tx_tready,
	input  logic                readout_pause,
	output logic                tx_tvalid,
	output logic                tx_tlast,
	output link_pkg::word_t     tx_data,
	output logic                sent
);

	localparam int idx_w  = $clog2(link_pkg::words_per_burst);
	localparam int word_w = $bits(link_pkg::word_t);

	// Idle, wait for the link, then one strobe cycle per word
	typedef enum logic [1:0] {
		tx_idle,
		tx_wait,
		tx_strobe
	} phase_t;

	logic [sync_stages-1:0] pause_sync;
	phase_t                 phase;
	link_pkg::word_sel_t    sel_q;
	logic [idx_w-1:0]       idx;
	logic                   go;
	logic                   final_word;
	link_pkg::word_t        next_word;

	//////////////////////////////////////////////////////////////////////
	// Pause synchronizer

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pause_sync <= '0;
		end else begin
			pause_sync <= {pause_sync[sync_stages-2:0], readout_pause};
		end
	end

	// Link ready and not paused, word goes out next cycle
	assign go = (phase == tx_wait) && tx_tready && !pause_sync[sync_stages-1];

	// Single word for csn and codes, four for a burst
	assign final_word = (sel_q != link_pkg::sel_burst) ||
		(idx == idx_w'(link_pkg::words_per_burst - 1));

	//////////////////////////////////////////////////////////////////////
	// Word select

	always_comb begin
		case (sel_q)
			link_pkg::sel_csn:    next_word = csn;
			link_pkg::sel_cc:     next_word = cc;
			link_pkg::sel_inv_cc: next_word = ~cc;
			// Quarter of the burst, low word first
			default:              next_word = burst[idx * word_w +: word_w];
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Phase control

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase     <= tx_idle;
			sel_q     <= link_pkg::sel_csn;
			idx       <= '0;
			tx_tvalid <= 1'b0;
			tx_tlast  <= 1'b0;
			sent      <= 1'b0;
		end else begin
			// One valid pulse per word, sent lines up with the final one
			tx_tvalid <= go;
			tx_tlast  <= go && final_word && last;
			sent      <= go && final_word;
			case (phase)
				tx_idle: begin
					if (send) begin
						sel_q <= word_sel;
						idx   <= '0;
						phase <= tx_wait;
					end
				end
				tx_wait: begin
					if (go)
						phase <= tx_strobe;
				end
				default: begin
					// idx still points at the word just strobed
					if (final_word) begin
						phase <= tx_idle;
					end else begin
						idx   <= idx + idx_w'(1);
						phase <= tx_wait;
					end
				end
			endcase
		end
	end

	// Data register, held until the next word is chosen
	always_ff @(posedge clk) begin
		if (go) begin
			tx_data <= next_word;
		end
	end

endmodule

// File: design/burst_fetch.sv
// Memory burst fetch
module burst_fetch #(
	parameter int sync_stages = 2
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   fetch_start,
	input  fill_pkg::burst_addr_t  start_addr,
	input  fill_pkg::burst_count_t start_count,
	input  logic                   fetch_req,
	input  logic                   advance,
	input  logic                   ddr3_one_burst_rdy,
	input  fill_pkg::header_t      ddr3_one_burst_data,
	output fill_pkg::burst_addr_t  ddr3_rd_burst_addr,
	output logic                   ddr3_rd_one_burst,
	output logic                   burst_ready,
	output fill_pkg::header_t      burst,
	output logic                   count_zero
);

	// Blanking covers the synchronizer plus the request cycle
	localparam int blank_w = $clog2(sync_stages + 2);

	logic [sync_stages-1:0]  rdy_sync;
	logic [blank_w-1:0]      blank_cnt;
	logic                    pending;
	logic                    rdy_seen;
	fill_pkg::burst_count_t  count;

	//////////////////////////////////////////////////////////////////////
	// Ready synchronizer

	// Memory ready is a level from another clock domain, at least two stages
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rdy_sync <= '0;
		end else begin
			rdy_sync <= {rdy_sync[sync_stages-2:0], ddr3_one_burst_rdy};
		end
	end

	// Stale high from the previous burst is masked while blank_cnt runs
	assign rdy_seen = pending && (blank_cnt == '0) && rdy_sync[sync_stages-1];

	//////////////////////////////////////////////////////////////////////
	// Request and capture

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ddr3_rd_one_burst <= 1'b0;
			burst_ready       <= 1'b0;
			pending           <= 1'b0;
			blank_cnt         <= '0;
		end else begin
			// One-cycle request strobe, one cycle after fetch_req
			ddr3_rd_one_burst <= fetch_req;
			burst_ready       <= rdy_seen;
			if (fetch_req) begin
				pending   <= 1'b1;
				blank_cnt <= blank_w'(sync_stages + 1);
			end else begin
				if (blank_cnt != '0)
					blank_cnt <= blank_cnt - blank_w'(1);
				if (rdy_seen)
					pending <= 1'b0;
			end
		end
	end

	// Burst data is stable once the synchronized ready is seen
	always_ff @(posedge clk) begin
		if (rdy_seen) begin
			burst <= ddr3_one_burst_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address and count

	// Zero flag is computed from the next count so it is valid a cycle after advance
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ddr3_rd_burst_addr <= '0;
			count              <= '0;
			count_zero         <= 1'b0;
		end else if (fetch_start) begin
			ddr3_rd_burst_addr <= start_addr;
			count              <= start_count;
			count_zero         <= (start_count == '0);
		end else if (advance) begin
			ddr3_rd_burst_addr <= ddr3_rd_burst_addr + fill_pkg::burst_addr_t'(1);
			count              <= count - fill_pkg::burst_count_t'(1);
			count_zero         <= (count == fill_pkg::burst_count_t'(1));
		end
	end

endmodule

// File: design/header_decode.sv
// Fill header decode and compare
module header_decode (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   hdr_take,
	input  fill_pkg::header_t      fifo_header,
	input  logic                   burst_ready,
	input  fill_pkg::header_t      burst,
	output logic                   fifo_rd_en,
	output fill_pkg::burst_addr_t  start_addr,
	output fill_pkg::burst_count_t start_count,
	output logic                   hdr_match
);

	// Header as it came out of the FIFO
	fill_pkg::header_t saved_header;

	//////////////////////////////////////////////////////////////////////
	// Header latch

	// FIFO runs first-word fall-through
	// Head entry is already on fifo_header when hdr_take pulses
	always_ff @(posedge clk) begin
		if (hdr_take) begin
			saved_header <= fifo_header;
		end
	end

	// Pop the entry in the cycle after the latch
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fifo_rd_en <= 1'b0;
		end else begin
			fifo_rd_en <= hdr_take;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Field extraction

	// Address and count load the fetch counters one cycle after hdr_take
	assign start_addr  = saved_header[fill_pkg::addr_msb:fill_pkg::addr_lsb];
	assign start_count = saved_header[fill_pkg::count_msb:fill_pkg::count_lsb];

	//////////////////////////////////////////////////////////////////////
	// Header compare

	// Full 128-bit compare against the memory copy
	// Burst register is fresh while burst_ready is high
	// Result holds until the next burst arrives
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hdr_match <= 1'b0;
		end else if (burst_ready) begin
			hdr_match <= (burst == saved_header);
		end
	end

endmodule

// File: design/link_pkg.sv
// Response link types
package link_pkg;

	// One word on the transmit link
	typedef logic [31:0] word_t;

	// A 128-bit burst goes out as four words, low word first
	localparam int words_per_burst = 4;

	// What the transmitter sends for one request
	// sel_csn     command serial number, one word
	// sel_cc      command code, one word
	// sel_inv_cc  inverted command code for an error, one word
	// sel_burst   current burst, four words
	typedef enum logic [1:0] {
		sel_csn,
		sel_cc,
		sel_inv_cc,
		sel_burst
	} word_sel_t;

endpackage

// File: design/fill_pkg.sv
// Fill header and memory burst types
package fill_pkg;

	////////////////////////////////////////////////////////////////////
	// Header and burst words

	// One fill header as held in the header FIFO
	// The memory copy of the header and every data burst have the same size
	typedef logic [127:0] header_t;

	// Burst address into the fill memory
	typedef logic [22:0] burst_addr_t;

	// Bursts still to send, header burst included
	typedef logic [20:0] burst_count_t;

	////////////////////////////////////////////////////////////////////
	// Header field positions

	// Start burst address of the fill, bits 35 to 57
	localparam int addr_lsb = 35;
	localparam int addr_msb = addr_lsb + $bits(burst_addr_t) - 1;

	// Burst count of the fill, bits 64 to 84
	localparam int count_lsb = 64;
	localparam int count_msb = count_lsb + $bits(burst_count_t) - 1;

	// Remaining header bits are carried through untouched
	// They only take part in the header compare

endpackage
